/* switch_pkg.sv */
`default_nettype none

package switch_pkg;

    localparam int DATA_W = 16;
    localparam int LEN_W  = 9;
    localparam int PRIO_W = 3;
    localparam int DEST_W = 4;

    // header layout, from the top: length, priority, destination.
    localparam int PRIO_LSB = DEST_W;
    localparam int LEN_LSB  = PRIO_W + DEST_W;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [DEST_W-1:0] dest_t;

    function automatic len_t hdr_len(word_t w);
        return w[LEN_LSB +: LEN_W];
    endfunction

    function automatic prio_t hdr_prio(word_t w);
        return w[PRIO_LSB +: PRIO_W];
    endfunction

    function automatic dest_t hdr_dest(word_t w);
        return w[DEST_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* pkt_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pkt_if
    import switch_pkg::*;
();

    logic  valid;
    logic  ready;
    logic  sop;
    logic  eop;
    word_t data;
    dest_t dest;
    prio_t prio;

    // dest and prio ride along with every word of a packet.
    modport src
    (
        output valid,
        output sop,
        output eop,
        output data,
        output dest,
        output prio,
        input  ready
    );

    modport snk
    (
        input  valid,
        input  sop,
        input  eop,
        input  data,
        input  dest,
        input  prio,
        output ready
    );

endinterface

`default_nettype wire

/* pkt_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_decoder
    import switch_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int PORT_ID   = 0
)
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_vld,
    input  logic  wr_sop,
    input  logic  wr_eop,
    input  word_t wr_data,
    output logic  wr_ready,
    pkt_if.src    out
);

    logic  out_vld;
    logic  out_sop;
    logic  out_eop;
    word_t out_data;
    dest_t dest_q;
    prio_t prio_q;
    logic  pkt_open;
    logic  discard;
    logic  accept;
    logic  bad_dest;
    logic  load;

    // a discarded packet is swallowed at full rate whatever the downstream does.
    assign wr_ready = discard || !out_vld || out.ready;
    assign accept   = wr_vld && wr_ready;
    assign bad_dest = int'(hdr_dest(wr_data)) >= NUM_PORTS;
    assign load     = accept && !discard && !(wr_sop && bad_dest);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_vld  <= 1'b0;
            pkt_open <= 1'b0;
            discard  <= 1'b0;
        end
        else
        begin
            if (load)
                out_vld <= 1'b1;
            else if (out.ready)
                out_vld <= 1'b0;

            if (accept)
            begin
                if (wr_eop)
                begin
                    pkt_open <= 1'b0;
                    discard  <= 1'b0;
                end
                else if (wr_sop)
                begin
                    pkt_open <= 1'b1;
                    discard  <= bad_dest;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_sop  <= wr_sop;
            out_eop  <= wr_eop;
            out_data <= wr_data;
            if (wr_sop)
            begin
                dest_q <= hdr_dest(wr_data);
                prio_q <= hdr_prio(wr_data);
            end
        end
    end

    assign out.valid = out_vld;
    assign out.sop   = out_sop;
    assign out.eop   = out_eop;
    assign out.data  = out_data;
    assign out.dest  = dest_q;
    assign out.prio  = prio_q;

    a_no_nested_sop: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && wr_sop |-> !pkt_open)
        else $error("decoder %0d: sop arrived inside an open packet", PORT_ID);

endmodule

`default_nettype wire

/* output_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module output_arbiter
    import switch_pkg::*;
#(
    parameter int NUM_PORTS = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req,
    input  prio_t                req_prio [NUM_PORTS],
    input  logic                 prio_en,
    input  logic                 eop_done,
    output logic [NUM_PORTS-1:0] grant,
    output logic                 busy
);

    localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [PTR_W-1:0]     ptr;
    logic [PTR_W-1:0]     grant_idx;
    logic [NUM_PORTS-1:0] grant_new;
    logic [NUM_PORTS-1:0] grant_q;
    prio_t                best_prio;
    logic                 found;
    int unsigned          idx;

    // with prio_en low the priority filter is skipped and this is plain round robin.
    always_comb
    begin
        best_prio = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (prio_en && req[i] && req_prio[i] > best_prio)
                best_prio = req_prio[i];
        end
        grant_new = '0;
        found     = 1'b0;
        idx       = 0;
        for (int off = 0; off < NUM_PORTS; off++)
        begin
            idx = (int'(ptr) + off) % NUM_PORTS;
            if (!found && req[idx] && (!prio_en || req_prio[idx] == best_prio))
            begin
                grant_new[idx] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    assign grant = busy ? grant_q : grant_new;

    always_comb
    begin
        grant_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (grant[i])
                grant_idx = PTR_W'(i);
        end
    end

    // the grant locks as soon as it is presented, so a stalled output word stays put.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            grant_q <= '0;
            ptr     <= '0;
        end
        else if (eop_done)
        begin
            busy <= 1'b0;
            ptr  <= (grant_idx == PTR_W'(NUM_PORTS - 1)) ? '0 : grant_idx + 1'b1;
        end
        else if (!busy && found)
        begin
            busy    <= 1'b1;
            grant_q <= grant_new;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !eop_done |=> $stable(grant));

endmodule

`default_nettype wire

/* switch_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_fabric
    import switch_pkg::*;
#(
    parameter int NUM_PORTS = 4
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic prio_en,
    pkt_if.snk   in_port  [NUM_PORTS],
    pkt_if.src   out_port [NUM_PORTS]
);

    logic                 in_vld   [NUM_PORTS];
    logic                 in_sop   [NUM_PORTS];
    logic                 in_eop   [NUM_PORTS];
    word_t                in_data  [NUM_PORTS];
    dest_t                in_dest  [NUM_PORTS];
    prio_t                in_prio  [NUM_PORTS];
    logic                 in_rdy   [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_grant [NUM_PORTS];
    logic [NUM_PORTS-1:0] req      [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant    [NUM_PORTS];
    logic                 eop_done [NUM_PORTS];
    logic                 mux_vld  [NUM_PORTS];
    logic                 mux_sop  [NUM_PORTS];
    logic                 mux_eop  [NUM_PORTS];
    word_t                mux_data [NUM_PORTS];
    logic                 out_rdy  [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_in
        assign in_vld[i]        = in_port[i].valid;
        assign in_sop[i]        = in_port[i].sop;
        assign in_eop[i]        = in_port[i].eop;
        assign in_data[i]       = in_port[i].data;
        assign in_dest[i]       = in_port[i].dest;
        assign in_prio[i]       = in_port[i].prio;
        assign in_port[i].ready = in_rdy[i];

        // an input is never granted by two outputs at once.
        a_one_output: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(in_grant[i]));
    end

    // only a waiting header competes for an output.
    always_comb
    begin
        for (int o = 0; o < NUM_PORTS; o++)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
                req[o][i] = in_vld[i] && in_sop[i] && (int'(in_dest[i]) == o);
        end
    end

    always_comb
    begin
        for (int o = 0; o < NUM_PORTS; o++)
        begin
            mux_vld[o]  = 1'b0;
            mux_sop[o]  = 1'b0;
            mux_eop[o]  = 1'b0;
            mux_data[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (grant[o][i])
                begin
                    mux_vld[o]  = in_vld[i];
                    mux_sop[o]  = in_sop[i];
                    mux_eop[o]  = in_eop[i];
                    mux_data[o] = in_data[i];
                end
            end
        end
    end

    // an input targets one output at a time, so at most one grant term is set here.
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            in_rdy[i] = 1'b0;
            for (int o = 0; o < NUM_PORTS; o++)
            begin
                in_grant[i][o] = grant[o][i];
                if (grant[o][i] && out_rdy[o])
                    in_rdy[i] = 1'b1;
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++)
    begin : g_out
        output_arbiter #(
            .NUM_PORTS (NUM_PORTS)
        ) u_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .req      (req[o]),
            .req_prio (in_prio),
            .prio_en  (prio_en),
            .eop_done (eop_done[o]),
            .grant    (grant[o]),
            .busy     ()
        );

        assign out_rdy[o]        = out_port[o].ready;
        assign eop_done[o]       = mux_vld[o] && out_rdy[o] && mux_eop[o];
        assign out_port[o].valid = mux_vld[o];
        assign out_port[o].sop   = mux_sop[o];
        assign out_port[o].eop   = mux_eop[o];
        assign out_port[o].data  = mux_data[o];
        assign out_port[o].dest  = dest_t'(o);
        assign out_port[o].prio  = '0;
    end

endmodule

`default_nettype wire

/* egress_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_framer
    import switch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    pkt_if.snk    in,
    output logic  rd_vld,
    output logic  rd_sop,
    output logic  rd_eop,
    output logic  rd_err,
    output word_t rd_data,
    input  logic  rd_ready
);

    localparam int CNT_W = LEN_W + 1;

    logic             load;
    len_t             len_q;
    len_t             len_cur;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_next;

    assign in.ready = !rd_vld || rd_ready;
    assign load     = in.valid && in.ready;

    // the header itself is not counted as payload.
    always_comb
    begin
        if (in.sop)
        begin
            len_cur  = hdr_len(in.data);
            cnt_next = '0;
        end
        else
        begin
            len_cur  = len_q;
            cnt_next = cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_vld <= 1'b0;
            rd_err <= 1'b0;
            cnt_q  <= '0;
        end
        else if (load)
        begin
            rd_vld <= 1'b1;
            rd_err <= in.eop && (cnt_next != {1'b0, len_cur});
            cnt_q  <= cnt_next;
        end
        else if (rd_ready)
        begin
            rd_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            rd_sop  <= in.sop;
            rd_eop  <= in.eop;
            rd_data <= in.data;
            len_q   <= len_cur;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld && !rd_ready |=> rd_vld && $stable(rd_data));

endmodule

`default_nettype wire

/* packet_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_switch
    import switch_pkg::*;
#(
    parameter int NUM_PORTS = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prio_en,
    input  logic [NUM_PORTS-1:0] wr_vld,
    input  logic [NUM_PORTS-1:0] wr_sop,
    input  logic [NUM_PORTS-1:0] wr_eop,
    input  word_t                wr_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0] wr_ready,
    output logic [NUM_PORTS-1:0] rd_vld,
    output logic [NUM_PORTS-1:0] rd_sop,
    output logic [NUM_PORTS-1:0] rd_eop,
    output logic [NUM_PORTS-1:0] rd_err,
    output word_t                rd_data [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] rd_ready
);

    pkt_if dec_if [NUM_PORTS] ();
    pkt_if eg_if  [NUM_PORTS] ();

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_dec
        pkt_decoder #(
            .NUM_PORTS (NUM_PORTS),
            .PORT_ID   (i)
        ) u_dec (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_vld   (wr_vld[i]),
            .wr_sop   (wr_sop[i]),
            .wr_eop   (wr_eop[i]),
            .wr_data  (wr_data[i]),
            .wr_ready (wr_ready[i]),
            .out      (dec_if[i])
        );
    end

    switch_fabric #(
        .NUM_PORTS (NUM_PORTS)
    ) u_fabric (
        .clk      (clk),
        .rst_n    (rst_n),
        .prio_en  (prio_en),
        .in_port  (dec_if),
        .out_port (eg_if)
    );

    for (genvar o = 0; o < NUM_PORTS; o++)
    begin : g_eg
        egress_framer u_framer (
            .clk      (clk),
            .rst_n    (rst_n),
            .in       (eg_if[o]),
            .rd_vld   (rd_vld[o]),
            .rd_sop   (rd_sop[o]),
            .rd_eop   (rd_eop[o]),
            .rd_err   (rd_err[o]),
            .rd_data  (rd_data[o]),
            .rd_ready (rd_ready[o])
        );
    end

endmodule

`default_nettype wire

/* tb_packet_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_packet_switch;
    import switch_pkg::*;

    localparam int NUM   = 4;
    localparam int NPKT  = 50;
    localparam longint WD_NS = longint'(NPKT + 4) * (13 + 4) * 40 * NUM;

    logic           clk;
    logic           rst_n;
    logic           prio_en;
    logic [NUM-1:0] wr_vld;
    logic [NUM-1:0] wr_sop;
    logic [NUM-1:0] wr_eop;
    word_t          wr_data [NUM];
    logic [NUM-1:0] wr_ready;
    logic [NUM-1:0] rd_vld;
    logic [NUM-1:0] rd_sop;
    logic [NUM-1:0] rd_eop;
    logic [NUM-1:0] rd_err;
    word_t          rd_data [NUM];
    logic [NUM-1:0] rd_ready;

    integer         seed = 32'hc9ec_ae33;
    int             mismatches = 0;
    int             failures = 0;
    bit             rand_ready = 0;
    bit [NUM-1:0]   took = '0;
    // each stream entry is {sop, eop, data}.
    logic [17:0]    st_q [NUM][$];
    word_t          exp_q [NUM*NUM][$];
    int             plen_q [NUM*NUM][$];
    logic           perr_q [NUM*NUM][$];
    word_t          cur_q [NUM][$];
    int             order_q [$];

    packet_switch #(
        .NUM_PORTS (NUM)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .prio_en  (prio_en),
        .wr_vld   (wr_vld),
        .wr_sop   (wr_sop),
        .wr_eop   (wr_eop),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .rd_vld   (rd_vld),
        .rd_sop   (rd_sop),
        .rd_eop   (rd_eop),
        .rd_err   (rd_err),
        .rd_data  (rd_data),
        .rd_ready (rd_ready)
    );

    always #20 clk = ~clk;

    task automatic check_word(word_t exp, word_t got, string name);
        if (exp !== got)
        begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic check_err(logic exp, logic got, string name);
        if (exp !== got)
        begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, got);
            mismatches++;
        end
    endtask

    // a header with zero length uses its source as priority and every payload starts
    // with the source id, so the first two words of a packet name its source.
    task automatic send_packet(int p, int dest, int len, int pr, bit bad);
        int   n;
        int   idx;
        word_t w;
        n   = bad ? len + 1 : len;
        idx = p * NUM + dest;
        if (len == 0)
            pr = p;
        w = {len_t'(len), prio_t'(pr), dest_t'(dest)};
        st_q[p].push_back({1'b1, n == 0, w});
        if (dest < NUM)
            exp_q[idx].push_back(w);
        for (int k = 0; k < n; k++)
        begin
            w = {4'(p), 12'($random(seed))};
            st_q[p].push_back({1'b0, k == n - 1, w});
            if (dest < NUM)
                exp_q[idx].push_back(w);
        end
        if (dest < NUM)
        begin
            plen_q[idx].push_back(n + 1);
            perr_q[idx].push_back(bad);
        end
    endtask

    task automatic finish_packet(int o, logic err);
        int src;
        int idx;
        int n;
        src = -1;
        for (int s = 0; s < NUM; s++)
        begin
            idx = s * NUM + o;
            if (src < 0 && plen_q[idx].size() > 0 && exp_q[idx][0] == cur_q[o][0])
            begin
                if (cur_q[o].size() < 2 || plen_q[idx][0] < 2 || exp_q[idx][1] == cur_q[o][1])
                    src = s;
            end
        end
        if (src < 0)
        begin
            $display("output %0d delivered a packet that no source sent, at %0t", o, $time);
            failures++;
        end
        else
        begin
            idx = src * NUM + o;
            n   = plen_q[idx].pop_front();
            for (int k = 0; k < n && k < cur_q[o].size(); k++)
                check_word(exp_q[idx][k], cur_q[o][k], $sformatf("rd_data[%0d]", o));
            if (n != cur_q[o].size())
            begin
                $display("output %0d packet length %0d words, sent %0d, at %0t",
                         o, cur_q[o].size(), n, $time);
                failures++;
            end
            for (int k = 0; k < n; k++)
                void'(exp_q[idx].pop_front());
            check_err(perr_q[idx].pop_front(), err, $sformatf("rd_err[%0d]", o));
            if (o == 0)
                order_q.push_back(src);
        end
        cur_q[o].delete();
    endtask

    function automatic bit drained();
        bit done;
        done = (wr_vld == '0) && (rd_vld == '0);
        for (int i = 0; i < NUM; i++)
            done = done && st_q[i].size() == 0;
        for (int i = 0; i < NUM * NUM; i++)
            done = done && plen_q[i].size() == 0;
        return done;
    endfunction

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            for (int p = 0; p < NUM; p++)
            begin
                if (wr_vld[p] && wr_ready[p])
                begin
                    void'(st_q[p].pop_front());
                    took[p] = 1'b1;
                end
                if (rd_vld[p] && rd_ready[p])
                begin
                    if (rd_sop[p] != (cur_q[p].size() == 0))
                    begin
                        $display("output %0d framing broken (sop %b) at %0t", p, rd_sop[p], $time);
                        failures++;
                    end
                    cur_q[p].push_back(rd_data[p]);
                    if (rd_eop[p])
                        finish_packet(p, rd_err[p]);
                    else
                        check_err(1'b0, rd_err[p], $sformatf("rd_err[%0d]", p));
                end
            end
        end
    end

    always @(negedge clk)
    begin
        for (int p = 0; p < NUM; p++)
        begin
            if (!(wr_vld[p] && !took[p]))
            begin
                if (st_q[p].size() > 0 && ($random(seed) & 3) != 0)
                    {wr_vld[p], wr_sop[p], wr_eop[p], wr_data[p]} = {1'b1, st_q[p][0]};
                else
                    wr_vld[p] = 1'b0;
            end
            took[p] = 1'b0;
            if (rand_ready)
                rd_ready[p] = 1'($random(seed));
        end
    end

    initial
    begin
        #(WD_NS);
        $display("watchdog expired after %0d ns with traffic still in flight", WD_NS);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        prio_en  = 1'b0;
        wr_vld   = '0;
        wr_sop   = '0;
        wr_eop   = '0;
        rd_ready = '0;
        for (int p = 0; p < NUM; p++)
            wr_data[p] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int p = 0; p < NUM; p++)
        begin
            check_err(1'b0, rd_vld[p], $sformatf("rd_vld[%0d]", p));
            check_err(1'b1, wr_ready[p], $sformatf("wr_ready[%0d]", p));
        end

        for (int k = 0; k < NPKT; k++)
        begin
            for (int p = 0; p < NUM; p++)
                send_packet(p, $unsigned($random(seed)) % 5, $unsigned($random(seed)) % 13,
                            $unsigned($random(seed)) % 8, ($random(seed) & 15) == 0);
        end
        rand_ready = 1'b1;
        while (!drained())
            @(posedge clk);

        // output 0 is held busy while two headers of different priority wait for it.
        @(negedge clk);
        rand_ready = 1'b0;
        rd_ready   = '1;
        rd_ready[0] = 1'b0;
        prio_en    = 1'b1;
        order_q.delete();
        send_packet(3, 0, 2, 0, 0);
        while (!rd_vld[0])
            @(posedge clk);
        send_packet(1, 0, 3, 2, 0);
        send_packet(2, 0, 3, 6, 0);
        while (!(wr_vld[1] && !wr_ready[1] && wr_vld[2] && !wr_ready[2]))
            @(posedge clk);
        @(negedge clk);
        rd_ready[0] = 1'b1;
        while (!drained())
            @(posedge clk);
        if (order_q.size() != 3 || order_q[0] != 3 || order_q[1] != 2 || order_q[2] != 1)
        begin
            $display("priority 6 packet did not leave output 0 ahead of priority 2");
            failures++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
switch_pkg.sv
pkt_if.sv
pkt_decoder.sv
output_arbiter.sv
switch_fabric.sv
egress_framer.sv
packet_switch.sv
tb_packet_switch.sv

/* Makefile */
TOP := tb_packet_switch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
